// ==== dv/tdc_core_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module tdc_core_tb;

	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 1;
	localparam int N_RANDOM = 20;
	localparam int N_MISS = 260;
	localparam int MAX_GAP = 40;
	localparam int OVF_RUN = 1100;
	localparam int DRAIN_LIMIT = 32;
	// Two long measurements and the overflow run are budgeted apart
	localparam int WATCHDOG_CYCLES = (N_RANDOM + N_MISS + 20) * MAX_GAP + 3 * OVF_RUN;

	typedef struct packed {
		logic [31:0] word;
		logic [31:0] due;
	} expect_t;

	logic CLK = 1'b0;
	logic rst;
	logic en;
	logic en_arm_mode;
	logic arm_flag;
	logic en_write_timestamp;
	logic [tdc_pkg::STAMP_BITS-1:0] timestamp;
	logic [tdc_pkg::TAP_BITS-1:0] trig_taps;
	logic [tdc_pkg::TAP_BITS-1:0] sig_taps;
	logic [tdc_pkg::WORD_BITS-1:0] out_word;
	logic out_valid;
	logic [tdc_pkg::MISS_BITS-1:0] miss_cnt;
	logic [tdc_pkg::ECNT_BITS-1:0] event_cnt;

	int cyc = 0;
	logic [31:0] lfsr = 32'hb16a;
	logic trig_fresh;
	logic sig_fresh;
	int exp_miss;
	int exp_events;
	expect_t exp_q[$];
	expect_t head;

	tdc_core DUT (
		.CLK(CLK),
		.rst(rst),
		.en(en),
		.en_arm_mode(en_arm_mode),
		.arm_flag(arm_flag),
		.en_write_timestamp(en_write_timestamp),
		.timestamp(timestamp),
		.trig_taps(trig_taps),
		.sig_taps(sig_taps),
		.out_word(out_word),
		.out_valid(out_valid),
		.miss_cnt(miss_cnt),
		.event_cnt(event_cnt)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// Index of the edge that captures what is driven now
	always @(posedge CLK) cyc <= cyc + 1;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		abort_run($sformatf("FAILED %s = 0x%h, expected 0x%h", name, got, want));
	endtask

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return val;
	endfunction

	function automatic logic [15:0] stamp_at(input int idx);
		return 16'(idx * 40503 + 11311);
	endfunction

	function automatic logic [31:0] meas_word(input logic [2:0] wtype, input logic ovf,
		input int coarse, input int fine);
		return {wtype, ovf, 10'(coarse), 7'(fine), 11'b0};
	endfunction

	function automatic logic [31:0] stamp_word(input int fine, input logic [15:0] stamp);
		return {tdc_pkg::WT_STAMP, 7'(fine), stamp, 6'b0};
	endfunction

	// Edge reached tap offset in the capture cycle
	function automatic logic [tdc_pkg::TAP_BITS-1:0] edge_taps(input int offset);
		return tdc_pkg::TAP_BITS'((65'd1 << (offset + 1)) - 65'd1);
	endfunction

	task automatic next_cycle();
		@(posedge CLK);
		#DRIVE_DELAY;
		// A launched edge fills the whole line one cycle later
		if (trig_fresh) begin
			trig_taps = '1;
			trig_fresh = 1'b0;
		end
		if (sig_fresh) begin
			sig_taps = '1;
			sig_fresh = 1'b0;
		end
		timestamp = stamp_at(cyc);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	// Fine position is the first zero tap, so offset plus one
	task automatic launch_edge(input logic on_sig, output int cap, output int fine);
		int offset;
		offset = int'(random_bits(6));
		if (on_sig) begin
			sig_taps = edge_taps(offset);
			sig_fresh = 1'b1;
		end else begin
			trig_taps = edge_taps(offset);
			trig_fresh = 1'b1;
		end
		cap = cyc;
		fine = offset + 1;
	endtask

	task automatic settle_lines();
		wait_cycles(2);
		trig_taps = '0;
		sig_taps = '0;
		next_cycle();
	endtask

	task automatic expect_word(input logic [31:0] word, input int cap);
		exp_q.push_back({word, 32'(cap + 4)});
	endtask

	task automatic measure(input int gap);
		int tcap;
		int tfine;
		int scap;
		int sfine;
		launch_edge(1'b0, tcap, tfine);
		if (en_write_timestamp) begin
			expect_word(stamp_word(tfine, stamp_at(tcap + 1)), tcap);
		end else begin
			expect_word(meas_word(tdc_pkg::WT_TRIG, 1'b0, 0, tfine), tcap);
		end
		wait_cycles(gap);
		launch_edge(1'b1, scap, sfine);
		expect_word(meas_word(tdc_pkg::WT_SIG, 1'b0, scap - tcap, sfine), scap);
		exp_events++;
		settle_lines();
	endtask

	task automatic lone_edge(input logic on_sig, input logic counted);
		int cap;
		int fine;
		launch_edge(on_sig, cap, fine);
		settle_lines();
		if (counted && exp_miss < 255) begin
			exp_miss++;
		end
	endtask

	task automatic arm_once();
		arm_flag = 1'b1;
		next_cycle();
		arm_flag = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			if (waited >= DRAIN_LIMIT) begin
				abort_run("pending output words never appeared");
			end else begin
				next_cycle();
				waited++;
			end
		end
	endtask

	task automatic check_counters();
		assert (miss_cnt == 8'(exp_miss))
			else report_mismatch("miss_cnt", 32'(miss_cnt), exp_miss);
		assert (event_cnt == exp_events)
			else report_mismatch("event_cnt", event_cnt, exp_events);
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		wait_cycles(2);
		rst = 1'b0;
		next_cycle();
		assert (!out_valid) else report_mismatch("out_valid", 32'(out_valid), 0);
	endtask

	// Every strobe must match the oldest expected word and its cycle
	always @(posedge CLK) begin
		if (!rst && out_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("output word produced when none was expected");
			end else begin
				head = exp_q.pop_front();
				assert (cyc == head.due)
					else report_mismatch("out_valid cycle", cyc, head.due);
				assert (out_word == head.word)
					else report_mismatch("out_word", out_word, head.word);
			end
		end else if (!rst && exp_q.size() != 0 && exp_q[0].due <= cyc) begin
			abort_run("expected output word did not appear in time");
		end
	end

	assert property (@(posedge CLK) rst |=> (!out_valid && miss_cnt == 0 && event_cnt == 0))
		else abort_run("out_valid or a counter not cleared by reset");

	// The accept cycle sits three edges before the strobe is seen
	assert property (@(posedge CLK) disable iff (rst) !$past(en, 3) |-> !out_valid)
		else abort_run("word produced while en was low");

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		int cap;
		int fine;
		rst = 1'b1;
		en = 1'b0;
		en_arm_mode = 1'b0;
		arm_flag = 1'b0;
		en_write_timestamp = 1'b0;
		timestamp = stamp_at(0);
		trig_taps = '0;
		sig_taps = '0;
		trig_fresh = 1'b0;
		sig_fresh = 1'b0;
		exp_miss = 0;
		exp_events = 0;
		apply_reset();
		check_counters();

		en = 1'b1;
		next_cycle();
		for (int i = 0; i < N_RANDOM; i++) begin
			measure(1 + int'(random_bits(5)));
		end
		measure(1);
		measure(1023);
		wait_drain();
		check_counters();

		en_write_timestamp = 1'b1;
		repeat (4) measure(1 + int'(random_bits(5)));
		wait_drain();
		en_write_timestamp = 1'b0;

		// Nothing on the signal line, counter runs out
		launch_edge(1'b0, cap, fine);
		expect_word(meas_word(tdc_pkg::WT_TRIG, 1'b0, 0, fine), cap);
		expect_word(meas_word(tdc_pkg::WT_OVF, 1'b1, 1023, 0), cap + 1024);
		wait_cycles(1028);
		settle_lines();
		wait_drain();
		measure(1 + int'(random_bits(5)));
		wait_drain();
		check_counters();

		repeat (3) lone_edge(1'b1, 1'b1);
		check_counters();
		repeat (N_MISS - 3) lone_edge(1'b1, 1'b1);
		check_counters();

		en = 1'b0;
		next_cycle();
		lone_edge(1'b0, 1'b0);
		lone_edge(1'b1, 1'b0);

		// Arm mode, one arm per measurement
		en_arm_mode = 1'b1;
		en = 1'b1;
		next_cycle();
		lone_edge(1'b0, 1'b0);
		lone_edge(1'b1, 1'b0);
		arm_once();
		measure(1 + int'(random_bits(5)));
		lone_edge(1'b0, 1'b0);
		arm_once();
		measure(1 + int'(random_bits(5)));
		wait_drain();
		check_counters();
		en_arm_mode = 1'b0;
		wait_cycles(2);

		// Reset lands while a trigger word is still in the pipeline
		launch_edge(1'b0, cap, fine);
		wait_cycles(3);
		apply_reset();
		exp_miss = 0;
		exp_events = 0;
		check_counters();
		settle_lines();
		measure(1 + int'(random_bits(5)));
		wait_drain();
		check_counters();

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/tdc_pkg.sv
source/tdl_hit_detector.sv
source/thermo_encoder.sv
source/coarse_counter.sv
source/tdc_controller.sv
source/delay_pipe.sv
source/word_broker.sv
source/tdc_core.sv
dv/tdc_core_tb.sv

// ==== source/coarse_counter.sv ====
`default_nettype none
`timescale 1ns/1ps

module coarse_counter (
	input wire logic CLK,
	input wire logic rst,
	input wire logic clr,
	output logic [tdc_pkg::COARSE_BITS-1:0] coarse,
	output logic ovf
);

	// Carry out of the increment is the overflow
	logic [tdc_pkg::COARSE_BITS:0] next_cnt;

	assign next_cnt = {1'b0, coarse} + 1'b1;

	always_ff @(posedge CLK) begin
		if (rst) begin
			coarse <= '0;
			ovf <= 1'b0;
		end else if (clr) begin
			// The clearing cycle already counts as one
			coarse <= tdc_pkg::COARSE_BITS'(1);
			ovf <= 1'b0;
		end else if (!ovf) begin
			if (next_cnt[tdc_pkg::COARSE_BITS]) begin
				ovf <= 1'b1;  // hold at the top value
			end else begin
				coarse <= next_cnt[tdc_pkg::COARSE_BITS-1:0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/delay_pipe.sv ====
`default_nettype none
`timescale 1ns/1ps

module delay_pipe #(
	parameter int DEPTH = 1,
	parameter int WIDTH = 1
) (
	input wire logic CLK,
	input wire logic rst,
	input wire logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout
);

	logic [DEPTH-1:0][WIDTH-1:0] stage;

	// MSB of each stage is the valid flag, the rest is payload
	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage[i][WIDTH-1] <= 1'b0;
			end
		end else begin
			stage[0] <= din;
			for (int i = 1; i < DEPTH; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign dout = stage[DEPTH-1];

endmodule

`default_nettype wire

// ==== source/tdc_controller.sv ====
`default_nettype none
`timescale 1ns/1ps

module tdc_controller (
	input wire logic CLK,
	input wire logic rst,
	input wire logic en,
	input wire logic en_arm_mode,
	input wire logic arm_flag,
	input wire logic en_write_timestamp,
	input wire logic [tdc_pkg::STAMP_BITS-1:0] timestamp,
	input wire logic trig_hit,
	input wire logic sig_hit,
	input wire logic [tdc_pkg::COARSE_BITS-1:0] coarse,
	input wire logic ovf,
	output logic count_clr,
	output logic line_sel,
	output tdc_pkg::tdc_event_t evt,
	output logic [tdc_pkg::MISS_BITS-1:0] miss_cnt,
	output logic [tdc_pkg::ECNT_BITS-1:0] event_cnt
);

	tdc_pkg::tdc_state_e state_q;
	tdc_pkg::tdc_state_e state_d;
	logic trig_accept;
	logic sig_accept;
	logic ovf_accept;
	logic miss;

	assign trig_accept = en && (state_q == tdc_pkg::ST_WAIT_TRIG) && trig_hit;
	// Overflow wins over a signal hit in the same cycle
	assign ovf_accept = en && (state_q == tdc_pkg::ST_WAIT_SIG) && ovf;
	assign sig_accept = en && (state_q == tdc_pkg::ST_WAIT_SIG) && !ovf && sig_hit;
	assign miss = en && (state_q == tdc_pkg::ST_WAIT_TRIG) && sig_hit;

	// Restart the coarse count on the trigger cycle
	assign count_clr = trig_accept;

	always_comb begin
		state_d = state_q;
		if (!en) begin
			state_d = tdc_pkg::ST_IDLE;
		end else begin
			case (state_q)
				tdc_pkg::ST_IDLE,
				tdc_pkg::ST_WAIT_ARM: begin
					if (en_arm_mode && !arm_flag) begin
						state_d = tdc_pkg::ST_WAIT_ARM;
					end else if (en_arm_mode || state_q == tdc_pkg::ST_IDLE) begin
						if (en_arm_mode && state_q == tdc_pkg::ST_IDLE) begin
							state_d = tdc_pkg::ST_WAIT_ARM;
						end else begin
							state_d = tdc_pkg::ST_WAIT_TRIG;
						end
					end else begin
						state_d = tdc_pkg::ST_WAIT_TRIG;
					end
				end
				tdc_pkg::ST_WAIT_TRIG: begin
					if (trig_hit) begin
						state_d = tdc_pkg::ST_WAIT_SIG;
					end
				end
				tdc_pkg::ST_WAIT_SIG: begin
					// Each finished measurement needs a new arm in arm mode
					if (ovf_accept || sig_accept) begin
						if (en_arm_mode) begin
							state_d = tdc_pkg::ST_WAIT_ARM;
						end else begin
							state_d = tdc_pkg::ST_WAIT_TRIG;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state_q <= tdc_pkg::ST_IDLE;
			line_sel <= tdc_pkg::LINE_TRIG;
			evt <= '0;
			miss_cnt <= '0;
			event_cnt <= '0;
		end else begin
			state_q <= state_d;
			// Encoder follows the signal line only while a signal is awaited
			if (state_d == tdc_pkg::ST_WAIT_SIG) begin
				line_sel <= tdc_pkg::LINE_SIG;
			end else begin
				line_sel <= tdc_pkg::LINE_TRIG;
			end

			evt.valid <= trig_accept || sig_accept || ovf_accept;
			evt.ovf <= ovf_accept;
			evt.coarse <= trig_accept ? '0 : coarse;
			evt.stamp <= timestamp;
			if (trig_accept) begin
				evt.kind <= en_write_timestamp ? tdc_pkg::WT_STAMP : tdc_pkg::WT_TRIG;
			end else if (ovf_accept) begin
				evt.kind <= tdc_pkg::WT_OVF;
			end else begin
				evt.kind <= tdc_pkg::WT_SIG;
			end

			if (sig_accept) begin
				event_cnt <= event_cnt + 1'b1;
			end
			// Signal edges without a trigger, saturating
			if (miss && miss_cnt != '1) begin
				miss_cnt <= miss_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/tdc_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module tdc_core (
	input wire logic CLK,
	input wire logic rst,
	input wire logic en,
	input wire logic en_arm_mode,
	input wire logic arm_flag,
	input wire logic en_write_timestamp,
	input wire logic [tdc_pkg::STAMP_BITS-1:0] timestamp,
	input wire logic [tdc_pkg::TAP_BITS-1:0] trig_taps,
	input wire logic [tdc_pkg::TAP_BITS-1:0] sig_taps,
	output logic [tdc_pkg::WORD_BITS-1:0] out_word,
	output logic out_valid,
	output logic [tdc_pkg::MISS_BITS-1:0] miss_cnt,
	output logic [tdc_pkg::ECNT_BITS-1:0] event_cnt
);

	logic trig_hit;
	logic sig_hit;
	logic line_sel;
	logic [tdc_pkg::TAP_BITS-1:0] sample;
	logic [tdc_pkg::FINE_BITS-1:0] position;
	logic count_clr;
	logic [tdc_pkg::COARSE_BITS-1:0] coarse;
	logic ovf;
	tdc_pkg::tdc_event_t evt;
	tdc_pkg::tdc_event_t evt_aligned;

	tdl_hit_detector i_detector (
		.CLK(CLK),
		.rst(rst),
		.trig_taps(trig_taps),
		.sig_taps(sig_taps),
		.line_sel(line_sel),
		.trig_hit(trig_hit),
		.sig_hit(sig_hit),
		.sample(sample)
	);

	thermo_encoder i_encoder (
		.CLK(CLK),
		.sample(sample),
		.position(position)
	);

	coarse_counter i_counter (
		.CLK(CLK),
		.rst(rst),
		.clr(count_clr),
		.coarse(coarse),
		.ovf(ovf)
	);

	tdc_controller i_controller (
		.CLK(CLK),
		.rst(rst),
		.en(en),
		.en_arm_mode(en_arm_mode),
		.arm_flag(arm_flag),
		.en_write_timestamp(en_write_timestamp),
		.timestamp(timestamp),
		.trig_hit(trig_hit),
		.sig_hit(sig_hit),
		.coarse(coarse),
		.ovf(ovf),
		.count_clr(count_clr),
		.line_sel(line_sel),
		.evt(evt),
		.miss_cnt(miss_cnt),
		.event_cnt(event_cnt)
	);

	// The event is registered one cycle after capture, the encoder needs two
	delay_pipe #(
		.DEPTH(tdc_pkg::ENC_LATENCY - 1),
		.WIDTH($bits(tdc_pkg::tdc_event_t))
	) i_event_pipe (
		.CLK(CLK),
		.rst(rst),
		.din(evt),
		.dout(evt_aligned)
	);

	word_broker i_broker (
		.CLK(CLK),
		.rst(rst),
		.evt(evt_aligned),
		.position(position),
		.out_word(out_word),
		.out_valid(out_valid)
	);

endmodule

`default_nettype wire

// ==== source/tdc_pkg.sv ====
`default_nettype none

package tdc_pkg;

	// Delay line geometry
	localparam int TAP_BITS = 64;
	localparam int TAP_GROUP = 8;
	localparam int N_GROUPS = TAP_BITS / TAP_GROUP;
	localparam int GROUP_POS_BITS = $clog2(TAP_GROUP);

	// Field widths
	localparam int FINE_BITS = 7;
	localparam int COARSE_BITS = 10;
	localparam int STAMP_BITS = 16;
	localparam int WORD_BITS = 32;
	localparam int WTYPE_BITS = 3;
	localparam int MISS_BITS = 8;
	localparam int ECNT_BITS = 32;

	// Cycles from encoder input to encoder result
	localparam int ENC_LATENCY = 2;

	// Encoder input select
	localparam logic LINE_TRIG = 1'b0;
	localparam logic LINE_SIG = 1'b1;

	// Output word types
	localparam logic [WTYPE_BITS-1:0] WT_TRIG = 3'd1;
	localparam logic [WTYPE_BITS-1:0] WT_SIG = 3'd2;
	localparam logic [WTYPE_BITS-1:0] WT_STAMP = 3'd3;
	localparam logic [WTYPE_BITS-1:0] WT_OVF = 3'd4;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_ARM,
		ST_WAIT_TRIG,
		ST_WAIT_SIG
	} tdc_state_e;

	// Valid sits in the MSB, the delay pipe relies on it
	typedef struct packed {
		logic valid;
		logic [WTYPE_BITS-1:0] kind;
		logic ovf;
		logic [COARSE_BITS-1:0] coarse;
		logic [STAMP_BITS-1:0] stamp;
	} tdc_event_t;

	typedef struct packed {
		logic [WTYPE_BITS-1:0] wtype;
		logic ovf;
		logic [COARSE_BITS-1:0] coarse;
		logic [FINE_BITS-1:0] fine;
		logic [WORD_BITS-WTYPE_BITS-1-COARSE_BITS-FINE_BITS-1:0] reserved;
	} meas_word_t;

	typedef struct packed {
		logic [WTYPE_BITS-1:0] wtype;
		logic [FINE_BITS-1:0] fine;
		logic [STAMP_BITS-1:0] stamp;
		logic [WORD_BITS-WTYPE_BITS-FINE_BITS-STAMP_BITS-1:0] reserved;
	} stamp_word_t;

	// Word type is in the top bits of both views
	typedef union packed {
		meas_word_t meas;
		stamp_word_t stamp;
	} tdc_word_u;

endpackage

`default_nettype wire

// ==== source/tdl_hit_detector.sv ====
`default_nettype none
`timescale 1ns/1ps

module tdl_hit_detector (
	input wire logic CLK,
	input wire logic rst,
	input wire logic [tdc_pkg::TAP_BITS-1:0] trig_taps,
	input wire logic [tdc_pkg::TAP_BITS-1:0] sig_taps,
	input wire logic line_sel,
	output logic trig_hit,
	output logic sig_hit,
	output logic [tdc_pkg::TAP_BITS-1:0] sample
);

	logic [tdc_pkg::TAP_BITS-1:0] trig_q;
	logic [tdc_pkg::TAP_BITS-1:0] sig_q;
	logic trig_prev0;
	logic sig_prev0;

	// Capture both snapshots every cycle
	always_ff @(posedge CLK) begin
		trig_q <= trig_taps;
		sig_q <= sig_taps;
	end

	// Tap 0 of the previous capture, per line
	// Starts high so a line already high out of reset is not a hit
	always_ff @(posedge CLK) begin
		if (rst) begin
			trig_prev0 <= 1'b1;
			sig_prev0 <= 1'b1;
		end else begin
			trig_prev0 <= trig_q[0];
			sig_prev0 <= sig_q[0];
		end
	end

	// Rising edge on the line input
	assign trig_hit = trig_q[0] & ~trig_prev0;
	assign sig_hit = sig_q[0] & ~sig_prev0;

	// line_sel comes straight from a controller flop, so it is glitch free
	// and already lines up with the captured sample
	always_comb begin
		if (line_sel == tdc_pkg::LINE_SIG) begin
			sample = sig_q;
		end else begin
			sample = trig_q;
		end
	end

endmodule

`default_nettype wire

// ==== source/thermo_encoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module thermo_encoder (
	input wire logic CLK,
	input wire logic [tdc_pkg::TAP_BITS-1:0] sample,
	output logic [tdc_pkg::FINE_BITS-1:0] position
);

	logic [tdc_pkg::N_GROUPS-1:0][tdc_pkg::GROUP_POS_BITS-1:0] grp_pos_q;
	logic [tdc_pkg::N_GROUPS-1:0] grp_full_q;
	logic [tdc_pkg::FINE_BITS-1:0] pos_c;

	// Lowest zero inside one group, meaningless when the group is all ones
	function automatic logic [tdc_pkg::GROUP_POS_BITS-1:0] first_zero(
		input logic [tdc_pkg::TAP_GROUP-1:0] bits
	);
		logic [tdc_pkg::GROUP_POS_BITS-1:0] pos;
		pos = '0;
		for (int i = tdc_pkg::TAP_GROUP - 1; i >= 0; i--) begin
			if (!bits[i]) begin
				pos = tdc_pkg::GROUP_POS_BITS'(i);
			end
		end
		return pos;
	endfunction

	// Stage one, per group search
	always_ff @(posedge CLK) begin
		for (int g = 0; g < tdc_pkg::N_GROUPS; g++) begin
			grp_full_q[g] <= &sample[g*tdc_pkg::TAP_GROUP +: tdc_pkg::TAP_GROUP];
			grp_pos_q[g] <= first_zero(sample[g*tdc_pkg::TAP_GROUP +: tdc_pkg::TAP_GROUP]);
		end
	end

	// Stage two, the lowest group that is not full wins
	// All groups full means the edge ran past the last tap
	always_comb begin
		pos_c = tdc_pkg::FINE_BITS'(tdc_pkg::TAP_BITS);
		for (int g = tdc_pkg::N_GROUPS - 1; g >= 0; g--) begin
			if (!grp_full_q[g]) begin
				pos_c = tdc_pkg::FINE_BITS'(g * tdc_pkg::TAP_GROUP)
					+ tdc_pkg::FINE_BITS'(grp_pos_q[g]);
			end
		end
	end

	always_ff @(posedge CLK) begin
		position <= pos_c;
	end

endmodule

`default_nettype wire

// ==== source/word_broker.sv ====
`default_nettype none
`timescale 1ns/1ps

module word_broker (
	input wire logic CLK,
	input wire logic rst,
	input wire tdc_pkg::tdc_event_t evt,
	input wire logic [tdc_pkg::FINE_BITS-1:0] position,
	output logic [tdc_pkg::WORD_BITS-1:0] out_word,
	output logic out_valid
);

	tdc_pkg::tdc_word_u word_c;

	always_comb begin
		word_c = '0;
		if (evt.kind == tdc_pkg::WT_STAMP) begin
			// Trigger with external timestamp
			word_c.stamp.wtype = evt.kind;
			word_c.stamp.fine = position;
			word_c.stamp.stamp = evt.stamp;
		end else begin
			word_c.meas.wtype = evt.kind;
			word_c.meas.ovf = evt.ovf;
			word_c.meas.coarse = evt.coarse;
			// No edge was sampled for an overflow
			if (evt.kind == tdc_pkg::WT_OVF) begin
				word_c.meas.fine = '0;
			end else begin
				word_c.meas.fine = position;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= evt.valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (evt.valid) begin
			out_word <= word_c;
		end
	end

endmodule

`default_nettype wire
